//--- ks_cfg_pkg.sv
// Width and pipeline constants of the adder
// DATA_W must be a power of two because the prefix tree has log2(DATA_W) rows
// Latency is fixed at PIPE_DEPTH cycles when the output is never stalled
`default_nettype none

package ks_cfg_pkg;

    ////////////////////
    // Datapath size
    ////////////////////

    // Operand width in bits
    localparam int DATA_W = 32;

    // One prefix row per doubling of the combine distance
    localparam int TREE_ROWS = $clog2(DATA_W);

    ////////////////////
    // Pipeline
    ////////////////////

    // pg stage, the tree rows, then the sum stage
    localparam int PIPE_DEPTH = TREE_ROWS + 2;

endpackage

`default_nettype wire

//--- ks_types_pkg.sv
// Types shared by the adder stages
// pg_bus_t is the payload of every link between the pg stage, the rows and the sum stage
`default_nettype none

package ks_types_pkg;

    import ks_cfg_pkg::*;

    ////////////////////
    // Vectors
    ////////////////////

    // Operand or sum value
    typedef logic [DATA_W-1:0] operand_t;

    // One bit per position, used for propagate and generate terms
    typedef logic [DATA_W-1:0] bitvec_t;

    ////////////////////
    // Stage payloads
    ////////////////////

    // Request at the adder input
    typedef struct packed {
        operand_t a;
        operand_t b;
        logic     cin;
    } add_req_t;

    // Running prefix state between stages
    typedef struct packed {
        bitvec_t half_sum;  // a ^ b, untouched by the tree
        bitvec_t grp_p;
        bitvec_t grp_g;
        logic    cin;
    } pg_bus_t;

    // Result at the adder output
    typedef struct packed {
        operand_t sum;
        logic     cout;
    } add_rsp_t;

endpackage

`default_nettype wire

//--- ks_pg_stage.sv
// First stage of the adder, one register deep
// The carry-in is folded into the bit 0 generate, so the tree needs no extra bit
// in_ready depends combinationally on pg_ready
`timescale 1ns/1ps
`default_nettype none

module ks_pg_stage
    import ks_types_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire add_req_t in_req,
    input  wire logic     in_valid,
    output logic          in_ready,
    output pg_bus_t       pg_out,
    output logic          pg_valid,
    input  wire logic     pg_ready
);

    pg_bus_t bus_d;
    pg_bus_t bus_q;
    logic    valid_q;
    logic    take;

    ////////////////////
    // Per-bit terms
    ////////////////////

    always_comb begin
        bus_d.half_sum = in_req.a ^ in_req.b;
        bus_d.grp_p    = in_req.a ^ in_req.b;
        bus_d.grp_g    = in_req.a & in_req.b;
        // Bit 0 also generates when it propagates the carry-in
        bus_d.grp_g[0] = bus_d.grp_g[0] | (bus_d.grp_p[0] & in_req.cin);
        bus_d.cin      = in_req.cin;
    end

    ////////////////////
    // Output register
    ////////////////////

    // Free when empty or when the next stage takes the current entry
    assign in_ready = !valid_q || pg_ready;
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            bus_q <= bus_d;
        end
    end

    assign pg_out   = bus_q;
    assign pg_valid = valid_q;

endmodule

`default_nettype wire

//--- ks_prefix_row.sv
// One Kogge-Stone prefix row as a single pipeline stage
// ROW_DIST must be a power of two below DATA_W; row k uses 2**k
// Bits below ROW_DIST already hold their final group terms and pass through
`timescale 1ns/1ps
`default_nettype none

module ks_prefix_row
    import ks_cfg_pkg::*;
    import ks_types_pkg::*;
#(
    parameter int ROW_DIST = 1
) (
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire pg_bus_t pg_in,
    input  wire logic    in_valid,
    output logic         in_ready,
    output pg_bus_t      pg_out,
    output logic         out_valid,
    input  wire logic    out_ready
);

    bitvec_t g_next;
    bitvec_t p_next;
    pg_bus_t bus_d;
    pg_bus_t bus_q;
    logic    valid_q;
    logic    take;

    ////////////////////
    // Cell array
    ////////////////////

    for (genvar i = 0; i < DATA_W; i++) begin : g_bit
        if (i < ROW_DIST) begin : g_pass
            assign g_next[i] = pg_in.grp_g[i];
            assign p_next[i] = pg_in.grp_p[i];
        end else if (i < 2 * ROW_DIST) begin : g_grey
            // Lower group ends at bit 0, so only the generate changes
            assign g_next[i] = pg_in.grp_g[i] | (pg_in.grp_p[i] & pg_in.grp_g[i-ROW_DIST]);
            assign p_next[i] = pg_in.grp_p[i];
        end else begin : g_black
            assign g_next[i] = pg_in.grp_g[i] | (pg_in.grp_p[i] & pg_in.grp_g[i-ROW_DIST]);
            assign p_next[i] = pg_in.grp_p[i] & pg_in.grp_p[i-ROW_DIST];
        end
    end

    always_comb begin
        bus_d.half_sum = pg_in.half_sum;
        bus_d.grp_p    = p_next;
        bus_d.grp_g    = g_next;
        bus_d.cin      = pg_in.cin;
    end

    ////////////////////
    // Output register
    ////////////////////

    assign in_ready = !valid_q || out_ready;
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // Holds while stalled
    always_ff @(posedge clk) begin
        if (take) begin
            bus_q <= bus_d;
        end
    end

    assign pg_out    = bus_q;
    assign out_valid = valid_q;

endmodule

`default_nettype wire

//--- ks_sum_stage.sv
// Last stage of the adder, one register deep
// Expects grp_g[i] to be the full carry out of bits i..0 including cin
// in_ready depends combinationally on out_ready
`timescale 1ns/1ps
`default_nettype none

module ks_sum_stage
    import ks_cfg_pkg::*;
    import ks_types_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire pg_bus_t pg_in,
    input  wire logic    in_valid,
    output logic         in_ready,
    output add_rsp_t     out_rsp,
    output logic         out_valid,
    input  wire logic    out_ready
);

    bitvec_t  carry_in;
    add_rsp_t rsp_d;
    add_rsp_t rsp_q;
    logic     valid_q;
    logic     take;

    ////////////////////
    // Sum bits
    ////////////////////

    // Carry into bit i is the group generate of bits below it
    assign carry_in = {pg_in.grp_g[DATA_W-2:0], pg_in.cin};

    always_comb begin
        rsp_d.sum  = pg_in.half_sum ^ carry_in;
        rsp_d.cout = pg_in.grp_g[DATA_W-1];
    end

    ////////////////////
    // Output register
    ////////////////////

    assign in_ready = !valid_q || out_ready;
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rsp_q <= rsp_d;
        end
    end

    assign out_rsp   = rsp_q;
    assign out_valid = valid_q;

endmodule

`default_nettype wire

//--- ks_adder_top.sv
// Pipelined Kogge-Stone adder, PIPE_DEPTH register stages deep
// One addition per cycle without back-pressure; results leave in input order
// in_ready is combinational from out_ready through the whole ready chain
`timescale 1ns/1ps
`default_nettype none

module ks_adder_top
    import ks_cfg_pkg::*;
    import ks_types_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire add_req_t in_req,
    input  wire logic     in_valid,
    output logic          in_ready,
    output add_rsp_t      out_rsp,
    output logic          out_valid,
    input  wire logic     out_ready
);

    // Link k feeds row k; link TREE_ROWS feeds the sum stage
    pg_bus_t row_bus   [TREE_ROWS+1];
    logic    row_valid [TREE_ROWS+1];
    logic    row_ready [TREE_ROWS+1];

    ////////////////////
    // Propagate/generate
    ////////////////////

    ks_pg_stage ks_pg_stage_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (in_req),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .pg_out   (row_bus[0]),
        .pg_valid (row_valid[0]),
        .pg_ready (row_ready[0])
    );

    ////////////////////
    // Prefix tree
    ////////////////////

    for (genvar k = 0; k < TREE_ROWS; k++) begin : g_row
        ks_prefix_row #(
            .ROW_DIST (1 << k)
        ) ks_prefix_row_i (
            .clk       (clk),
            .arst_n    (arst_n),
            .pg_in     (row_bus[k]),
            .in_valid  (row_valid[k]),
            .in_ready  (row_ready[k]),
            .pg_out    (row_bus[k+1]),
            .out_valid (row_valid[k+1]),
            .out_ready (row_ready[k+1])
        );
    end

    ////////////////////
    // Sum
    ////////////////////

    ks_sum_stage ks_sum_stage_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .pg_in     (row_bus[TREE_ROWS]),
        .in_valid  (row_valid[TREE_ROWS]),
        .in_ready  (row_ready[TREE_ROWS]),
        .out_rsp   (out_rsp),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

//--- ks_adder_chk.sv
// Handshake and timing assertions for ks_adder_top, attached by bind
// The latency rule applies only when out_ready stayed high during the flight
`timescale 1ns/1ps
`default_nettype none

module ks_adder_chk
    import ks_cfg_pkg::*;
    import ks_types_pkg::*;
(
    input wire logic     clk,
    input wire logic     arst_n,
    input wire logic     in_valid,
    input wire logic     in_ready,
    input wire add_rsp_t out_rsp,
    input wire logic     out_valid,
    input wire logic     out_ready
);

    // Input transfers and out_ready over the last cycles
    logic [PIPE_DEPTH-1:0] xfer_hist;
    logic [PIPE_DEPTH-2:0] ready_hist;
    // Results held inside the pipeline registers
    int                    occupancy;
    int                    fail_cnt = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            xfer_hist  <= '0;
            ready_hist <= '0;
            occupancy  <= 0;
        end else begin
            xfer_hist  <= {xfer_hist[PIPE_DEPTH-2:0], in_valid && in_ready};
            ready_hist <= {ready_hist[PIPE_DEPTH-3:0], out_ready};
            if ((in_valid && in_ready) && !(out_valid && out_ready)) begin
                occupancy <= occupancy + 1;
            end else if (!(in_valid && in_ready) && (out_valid && out_ready)) begin
                occupancy <= occupancy - 1;
            end
        end
    end

    ////////////////////
    // Assertions
    ////////////////////

    a_reset_idle: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else begin
            fail_cnt++;
            $error("out_valid high during reset");
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_rsp))
        else begin
            fail_cnt++;
            $error("output changed while stalled");
        end

    // Input stalls only with every stage full and the sink stalled
    a_ready_path: assert property (@(posedge clk) disable iff (!arst_n)
        !in_ready |-> !out_ready && occupancy == PIPE_DEPTH)
        else begin
            fail_cnt++;
            $error("in_ready low with a free stage or a ready sink");
        end

    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        xfer_hist[PIPE_DEPTH-1] && (&ready_hist) |-> out_valid)
        else begin
            fail_cnt++;
            $error("result missing PIPE_DEPTH cycles after input");
        end

endmodule

bind ks_adder_top ks_adder_chk ks_adder_chk_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_rsp   (out_rsp),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

`default_nettype wire

//--- tb_ks_adder.sv
// Testbench for the pipelined Kogge-Stone adder
// Latency and rate checks hold only while out_ready stays high
// Reads the failure count of the bound checker instance at the end
`timescale 1ns/1ps
`default_nettype none

module tb_ks_adder
    import ks_cfg_pkg::*;
    import ks_types_pkg::*;
();

    localparam int       WAIT_LIMIT = 200;
    localparam operand_t ONES       = '1;
    localparam operand_t ALT_A      = {(DATA_W/2){2'b01}};
    localparam operand_t ALT_B      = ~ALT_A;

    logic     clk = 1'b0;
    logic     arst_n;
    add_req_t in_req;
    logic     in_valid;
    logic     in_ready;
    add_rsp_t out_rsp;
    logic     out_valid;
    logic     out_ready;

    // Accepted requests with the cycle they were taken in
    add_req_t exp_q [$];
    int       cyc_q [$];
    int       cycle_cnt = 0;
    int       in_cnt = 0;
    int       out_cnt = 0;
    int       last_rsp = -1;
    int       sb_errs = 0;
    int       ctl_errs = 0;
    logic     stall_mode;
    logic     check_lat;
    logic     check_rate;

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ks_adder_top ks_adder_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_req    (in_req),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_rsp   (out_rsp),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    ////////////////////
    // Scoreboard
    ////////////////////

    // Mid-cycle sampling, the transfer itself happens on the next rising edge
    always @(negedge clk) begin : monitor
        add_req_t        req;
        logic [DATA_W:0] exp_val;
        int              issued;
        if (!check_rate) begin
            last_rsp = -1;
        end
        if (arst_n && in_valid && in_ready) begin
            exp_q.push_back(in_req);
            cyc_q.push_back(cycle_cnt);
            in_cnt++;
        end
        if (arst_n && out_valid && out_ready) begin
            out_cnt++;
            if (exp_q.size() == 0) begin
                $display("%0t: response arrived with no request outstanding", $time);
                sb_errs++;
            end else begin
                req     = exp_q.pop_front();
                issued  = cyc_q.pop_front();
                exp_val = {1'b0, req.a} + {1'b0, req.b} + {{DATA_W{1'b0}}, req.cin};
                assert (out_rsp.sum == exp_val[DATA_W-1:0]) else begin
                    $display("FAIL %0t out_rsp.sum expected %h actual %h",
                             $time, exp_val[DATA_W-1:0], out_rsp.sum);
                    sb_errs++;
                end
                assert (out_rsp.cout == exp_val[DATA_W]) else begin
                    $display("FAIL %0t out_rsp.cout expected %b actual %b",
                             $time, exp_val[DATA_W], out_rsp.cout);
                    sb_errs++;
                end
                if (check_lat) begin
                    assert (cycle_cnt - issued == PIPE_DEPTH) else begin
                        $display("FAIL %0t out_valid latency expected %0d actual %0d",
                                 $time, PIPE_DEPTH, cycle_cnt - issued);
                        sb_errs++;
                    end
                end
                if (check_rate) begin
                    if (last_rsp >= 0) begin
                        assert (cycle_cnt == last_rsp + 1) else begin
                            $display("FAIL %0t out_valid result cycle expected %0d actual %0d",
                                     $time, last_rsp + 1, cycle_cnt);
                            sb_errs++;
                        end
                    end
                    last_rsp = cycle_cnt;
                end
            end
        end
    end

    ////////////////////
    // Driver tasks
    ////////////////////

    function automatic add_req_t make_req(operand_t a, operand_t b, logic cin);
        add_req_t req;
        req.a   = a;
        req.b   = b;
        req.cin = cin;
        return req;
    endfunction

    task automatic check_idle();
        assert (!out_valid) else begin
            $display("FAIL %0t out_valid expected 0 actual %b", $time, out_valid);
            ctl_errs++;
        end
        assert (in_ready) else begin
            $display("FAIL %0t in_ready expected 1 actual %b", $time, in_ready);
            ctl_errs++;
        end
    endtask

    // Holds the request until accepted, returns 2 ns after the accepting edge
    task automatic send_req(input add_req_t req);
        int   waited;
        logic taken;
        waited   = 0;
        taken    = 1'b0;
        in_req   = req;
        in_valid = 1'b1;
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #2;
            waited++;
        end
        in_valid = 1'b0;
        if (!taken) begin
            $display("%0t: request not accepted within %0d cycles", $time, WAIT_LIMIT);
            ctl_errs++;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited   = 0;
        in_valid = 1'b0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0t: pipeline did not drain, %0d results missing", $time, exp_q.size());
            ctl_errs++;
        end
    endtask

    // Random low stretches of out_ready while stall_mode is set
    task automatic drive_ready();
        int stretch;
        stretch = 0;
        forever begin
            @(posedge clk);
            #2;
            if (!stall_mode) begin
                out_ready = 1'b1;
            end else if (stretch > 0) begin
                stretch--;
            end else begin
                out_ready = !out_ready;
                stretch   = $urandom_range(6, 0);
            end
        end
    endtask

    ////////////////////
    // Sequence
    ////////////////////

    initial begin
        operand_t    a_val;
        operand_t    b_val;
        logic [31:0] rnd;
        int          asrt_errs;
        void'($urandom(32'hec15));
        in_req     = '0;
        in_valid   = 1'b0;
        out_ready  = 1'b1;
        arst_n     = 1'b1;
        stall_mode = 1'b0;
        check_lat  = 1'b0;
        check_rate = 1'b0;
        fork
            drive_ready();
        join_none
        #1;
        arst_n = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #1;
            check_idle();
        end
        #1;
        arst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #2;

        // Random operands with the odd idle cycle
        check_lat = 1'b1;
        for (int n = 0; n < 300; n++) begin
            a_val = $urandom;
            b_val = $urandom;
            rnd   = $urandom;
            send_req(make_req(a_val, b_val, rnd[0]));
            if (rnd[3:1] == 3'd0) begin
                @(posedge clk);
                #2;
            end
        end

        // Carries that ripple through every row
        send_req(make_req(ONES, '0, 1'b1));
        send_req(make_req(ONES, ONES, 1'b0));
        send_req(make_req(ONES, ONES, 1'b1));
        send_req(make_req('0, '0, 1'b0));
        send_req(make_req('0, '0, 1'b1));
        send_req(make_req(ALT_A, ALT_B, 1'b1));
        send_req(make_req(ALT_A, ALT_B, 1'b0));
        send_req(make_req(ALT_A, ALT_A, 1'b1));
        send_req(make_req(ALT_B, ALT_B, 1'b0));
        send_req(make_req(ONES, operand_t'(1), 1'b0));
        wait_drain();

        // Back-pressure with a busy input
        check_lat  = 1'b0;
        stall_mode = 1'b1;
        for (int n = 0; n < 200; n++) begin
            a_val = $urandom;
            b_val = $urandom;
            rnd   = $urandom;
            send_req(make_req(a_val, b_val, rnd[0]));
        end
        stall_mode = 1'b0;
        wait_drain();

        // Full rate burst
        check_lat  = 1'b1;
        check_rate = 1'b1;
        for (int n = 0; n < 40; n++) begin
            a_val = $urandom;
            b_val = $urandom;
            rnd   = $urandom;
            send_req(make_req(a_val, b_val, rnd[0]));
        end
        wait_drain();
        check_rate = 1'b0;

        if (in_cnt != out_cnt) begin
            $display("%0t: %0d requests accepted but %0d results delivered",
                     $time, in_cnt, out_cnt);
            ctl_errs++;
        end
        asrt_errs = ks_adder_top_i.ks_adder_chk_i.fail_cnt;
        $display("Errors: scoreboard %0d, control %0d, assertions %0d over %0d results",
                 sb_errs, ctl_errs, asrt_errs, out_cnt);
        if (sb_errs + ctl_errs + asrt_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
ks_cfg_pkg.sv
ks_types_pkg.sv
ks_pg_stage.sv
ks_prefix_row.sv
ks_sum_stage.sv
ks_adder_top.sv
ks_adder_chk.sv
tb_ks_adder.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the adder testbench with Verilator and runs it.
# Exit status is 0 only when the run prints the pass line.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f project.f \
        --top-module tb_ks_adder -o sim_ks_adder; then
    echo "Verilator build failed"
    exit 1
fi

# A high error limit lets assertion failures reach the testbench summary
if ! sim_out=$(./obj_dir/sim_ks_adder +verilator+error+limit+1000 2>&1); then
    printf '%s\n' "$sim_out"
    echo "Simulation exited with an error"
    exit 1
fi
printf '%s\n' "$sim_out"

if grep -qx "RESULT: PASS" <<< "$sim_out"; then
    exit 0
else
    echo "Pass line not found in simulation output"
    exit 1
fi
